/* src/fir_pkg.sv */
`default_nettype none

package fir_pkg;

	// filter geometry
	localparam int fir_taps = 8;
	localparam int sample_width = 14;
	localparam int coef_width = 18;

	// fractional bits of a coefficient, also the output scaling shift
	localparam int coef_mag = 17;

	// headroom for summing eight full-scale products
	localparam int guard_bits = 3;
	localparam int prod_width = sample_width + coef_width;
	localparam int sum_width = prod_width + guard_bits;

	// datapath words, all two's complement
	typedef logic signed [sample_width-1:0] sample_t;
	typedef logic signed [coef_width-1:0] coef_t;
	typedef logic signed [prod_width-1:0] prod_t;
	typedef logic signed [sum_width-1:0] sum_t;

	// every tap coefficient in one vector, tap 0 in the low bits
	typedef coef_t [fir_taps-1:0] coef_set_t;

	// output saturation limits
	localparam sample_t sample_max = sample_t'((1 << (sample_width - 1)) - 1);
	localparam sample_t sample_min = sample_t'(-(1 << (sample_width - 1)));

endpackage

`default_nettype wire

/* src/axi_regs_pkg.sv */
`default_nettype none

package axi_regs_pkg;

	// bus geometry
	localparam int axi_addr_width = 16;
	localparam int axi_data_width = 32;
	// byte offset bits inside a 32 bit word
	localparam int addr_lsb = 2;
	localparam int word_addr_width = axi_addr_width - addr_lsb;

	typedef logic [word_addr_width-1:0] word_addr_t;
	typedef logic [axi_data_width-1:0] axi_data_t;

	// response code, only okay is ever returned
	localparam logic [1:0] resp_okay = 2'b00;

	// word addresses of the register map
	localparam word_addr_t reg_prog_name = 0;
	localparam word_addr_t reg_prog_ver = 1;
	localparam word_addr_t reg_prog_stat = 2;
	localparam word_addr_t reg_tap_count = 4;
	localparam word_addr_t reg_coef_mag = 8;
	localparam word_addr_t reg_coef_base = 16;
	localparam word_addr_t reg_switches = 20;
	// first coefficient word, one word per tap after it
	localparam word_addr_t coef_base = 32;

	// identification strings, byte reversed so they read right in memory
	localparam axi_data_t prog_name = " RIF";
	localparam axi_data_t prog_ver = "01.3";
	localparam axi_data_t prog_stat = "VED ";

	// switch register fields
	localparam int sw_fir_en = 1;
	localparam int sw_leds_lsb = 0;
	localparam int sw_leds_width = 8;

	// single cycle register write request
	typedef struct packed {
		logic en;
		word_addr_t addr;
		axi_data_t data;
	} reg_wr_t;

	// register read request, data comes back combinationally
	typedef struct packed {
		word_addr_t addr;
	} reg_rd_t;

endpackage

`default_nettype wire

/* src/axi_lite_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// write address and data channels
	input wire [axi_regs_pkg::axi_addr_width-1:0] S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input wire [axi_regs_pkg::axi_data_width-1:0] S_AXI_WDATA,
	input wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	// write response channel
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input wire S_AXI_BREADY,
	// read address and data channels
	input wire [axi_regs_pkg::axi_addr_width-1:0] S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output logic [axi_regs_pkg::axi_data_width-1:0] S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input wire S_AXI_RREADY,
	// register side
	output axi_regs_pkg::reg_wr_t wr,
	output axi_regs_pkg::reg_rd_t rd,
	input wire axi_regs_pkg::axi_data_t rd_data
);

	import axi_regs_pkg::*;

	// write side state
	logic awready_q;
	logic wready_q;
	// high while no write response is outstanding
	logic aw_en_q;
	logic bvalid_q;
	word_addr_t awaddr_q;

	// read side state
	logic arready_q;
	logic rvalid_q;
	word_addr_t araddr_q;
	axi_data_t rdata_q;

	logic aw_start;
	logic ar_start;
	logic wr_en;
	logic rd_en;

	// accept address and data together, only one write in flight
	assign aw_start = ~awready_q && S_AXI_AWVALID && S_AXI_WVALID && aw_en_q;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			awready_q <= 1'b0;
			wready_q <= 1'b0;
			aw_en_q <= 1'b1;
			awaddr_q <= '0;
		end else begin
			// both readies pulse for a single cycle
			awready_q <= aw_start;
			wready_q <= aw_start;
			if (aw_start) begin
				aw_en_q <= 1'b0;
				// drop the byte offset
				awaddr_q <= S_AXI_AWADDR[axi_addr_width-1:addr_lsb];
			end else if (S_AXI_BREADY && bvalid_q) begin
				// response taken, next write may start
				aw_en_q <= 1'b1;
			end
		end
	end

	// write handshake completes in the ready cycle
	assign wr_en = awready_q && S_AXI_AWVALID && wready_q && S_AXI_WVALID;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			bvalid_q <= 1'b0;
		end else if (wr_en && ~bvalid_q) begin
			bvalid_q <= 1'b1;
		end else if (S_AXI_BREADY && bvalid_q) begin
			bvalid_q <= 1'b0;
		end
	end

	// read accept waits for a pending response to drain
	assign ar_start = ~arready_q && S_AXI_ARVALID && ~rvalid_q;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			arready_q <= 1'b0;
			araddr_q <= '0;
		end else begin
			arready_q <= ar_start;
			if (ar_start) begin
				araddr_q <= S_AXI_ARADDR[axi_addr_width-1:addr_lsb];
			end
		end
	end

	assign rd_en = arready_q && S_AXI_ARVALID && ~rvalid_q;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			rvalid_q <= 1'b0;
			rdata_q <= '0;
		end else begin
			if (rd_en) begin
				rvalid_q <= 1'b1;
				// sample the decoded word once per read
				rdata_q <= rd_data;
			end else if (rvalid_q && S_AXI_RREADY) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// requests towards the register bank
	always_comb begin
		wr.en = wr_en;
		wr.addr = awaddr_q;
		wr.data = S_AXI_WDATA;
		rd.addr = araddr_q;
	end

	// bus outputs
	assign S_AXI_AWREADY = awready_q;
	assign S_AXI_WREADY = wready_q;
	assign S_AXI_BVALID = bvalid_q;
	assign S_AXI_BRESP = resp_okay;
	assign S_AXI_ARREADY = arready_q;
	assign S_AXI_RVALID = rvalid_q;
	assign S_AXI_RDATA = rdata_q;
	assign S_AXI_RRESP = resp_okay;

endmodule

`default_nettype wire

/* src/fir_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_reg_bank (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire axi_regs_pkg::reg_wr_t wr,
	input wire axi_regs_pkg::reg_rd_t rd,
	output axi_regs_pkg::axi_data_t rd_data,
	output fir_pkg::coef_set_t coefs,
	output logic fir_en,
	output logic [axi_regs_pkg::sw_leds_width-1:0] leds
);

	import fir_pkg::*;
	import axi_regs_pkg::*;

	axi_data_t switches_q;
	coef_set_t coefs_q;

	// write decode
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches_q <= '0;
			coefs_q <= '0;
		end else if (wr.en) begin
			if (wr.addr == reg_switches) begin
				switches_q <= wr.data;
			end
			for (int k = 0; k < fir_taps; k++) begin
				if (wr.addr == word_addr_t'(coef_base + k)) begin
					// sign from bit 31, magnitude bits from the bottom
					coefs_q[k] <= {wr.data[axi_data_width-1], wr.data[coef_width-2:0]};
				end
			end
		end
	end

	// read decode, unmapped words give zero
	always_comb begin
		case (rd.addr)
			reg_prog_name: rd_data = prog_name;
			reg_prog_ver: rd_data = prog_ver;
			reg_prog_stat: rd_data = prog_stat;
			reg_tap_count: rd_data = axi_data_t'(fir_taps);
			reg_coef_mag: rd_data = axi_data_t'(coef_mag);
			reg_coef_base: rd_data = axi_data_t'(coef_base);
			reg_switches: rd_data = switches_q;
			default: rd_data = '0;
		endcase
		// coefficient window
		for (int k = 0; k < fir_taps; k++) begin
			if (rd.addr == word_addr_t'(coef_base + k)) begin
				// sign extend to the full bus word
				rd_data = {{(axi_data_width - coef_width){coefs_q[k][coef_width-1]}},
					coefs_q[k]};
			end
		end
	end

	// control outputs
	assign coefs = coefs_q;
	assign fir_en = switches_q[sw_fir_en];
	assign leds = switches_q[sw_leds_lsb +: sw_leds_width];

endmodule

`default_nettype wire

/* src/fir_tap_chain.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_tap_chain (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire fir_pkg::sample_t fir_in,
	input wire fir_pkg::coef_set_t coefs,
	output fir_pkg::sum_t sum
);

	import fir_pkg::*;

	// delay_q[k] holds the sample from k cycles back
	sample_t delay_q [fir_taps];
	// one coefficient per tap, signed
	coef_t coef_tap [fir_taps];
	prod_t prod_q [fir_taps];
	sum_t sum_next;
	sum_t sum_q;

	// sample shift register
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			delay_q <= '{default: '0};
		end else begin
			delay_q[0] <= fir_in;
			for (int k = 1; k < fir_taps; k++) begin
				delay_q[k] <= delay_q[k-1];
			end
		end
	end

	// split the packed set per tap
	always_comb begin
		for (int k = 0; k < fir_taps; k++) begin
			coef_tap[k] = coefs[k];
		end
	end

	// one registered multiplier per tap
	always_ff @(posedge S_AXI_ACLK) begin
		for (int k = 0; k < fir_taps; k++) begin
			prod_q[k] <= prod_t'(delay_q[k]) * prod_t'(coef_tap[k]);
		end
	end

	// adder tree, guard bits absorb the growth
	always_comb begin
		sum_next = '0;
		for (int k = 0; k < fir_taps; k++) begin
			sum_next = sum_next + sum_t'(prod_q[k]);
		end
	end

	// registered sum, third stage after the input
	always_ff @(posedge S_AXI_ACLK) begin
		sum_q <= sum_next;
	end

	assign sum = sum_q;

endmodule

`default_nettype wire

/* src/fir_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_output_stage (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire fir_pkg::sum_t sum,
	input wire fir_pkg::sample_t fir_in,
	input wire fir_en,
	output fir_pkg::sample_t fir_out
);

	import fir_pkg::*;

	sum_t scaled;
	sample_t sat;
	sample_t out_q;

	// drop the coefficient fraction, arithmetic shift floors
	assign scaled = sum >>> coef_mag;

	// clamp to the sample range
	always_comb begin
		if (scaled > sum_t'(sample_max)) begin
			sat = sample_max;
		end else if (scaled < sum_t'(sample_min)) begin
			sat = sample_min;
		end else begin
			sat = sample_t'(scaled);
		end
	end

	// filtered or raw sample, one register either way
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			out_q <= '0;
		end else begin
			out_q <= fir_en ? sat : fir_in;
		end
	end

	assign fir_out = out_q;

endmodule

`default_nettype wire

/* src/fir_axi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_axi_top (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire [axi_regs_pkg::axi_addr_width-1:0] S_AXI_AWADDR,
	input wire S_AXI_AWVALID,
	output wire S_AXI_AWREADY,
	input wire [axi_regs_pkg::axi_data_width-1:0] S_AXI_WDATA,
	input wire S_AXI_WVALID,
	output wire S_AXI_WREADY,
	output wire [1:0] S_AXI_BRESP,
	output wire S_AXI_BVALID,
	input wire S_AXI_BREADY,
	input wire [axi_regs_pkg::axi_addr_width-1:0] S_AXI_ARADDR,
	input wire S_AXI_ARVALID,
	output wire S_AXI_ARREADY,
	output wire [axi_regs_pkg::axi_data_width-1:0] S_AXI_RDATA,
	output wire [1:0] S_AXI_RRESP,
	output wire S_AXI_RVALID,
	input wire S_AXI_RREADY,
	// sample stream
	input wire fir_pkg::sample_t fir_in,
	output wire fir_pkg::sample_t fir_out,
	output wire [axi_regs_pkg::sw_leds_width-1:0] leds
);

	import fir_pkg::*;
	import axi_regs_pkg::*;

	// register access
	wire reg_wr_t wr;
	wire reg_rd_t rd;
	wire axi_data_t rd_data;
	// filter control and data
	wire coef_set_t coefs;
	wire fir_en;
	wire sum_t sum;

	// bus front end
	axi_lite_slave axi_lite_slave_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(S_AXI_AWADDR), .S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY), .S_AXI_WDATA(S_AXI_WDATA),
		.S_AXI_WVALID(S_AXI_WVALID), .S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BRESP(S_AXI_BRESP), .S_AXI_BVALID(S_AXI_BVALID),
		.S_AXI_BREADY(S_AXI_BREADY), .S_AXI_ARADDR(S_AXI_ARADDR),
		.S_AXI_ARVALID(S_AXI_ARVALID), .S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_RDATA(S_AXI_RDATA), .S_AXI_RRESP(S_AXI_RRESP),
		.S_AXI_RVALID(S_AXI_RVALID), .S_AXI_RREADY(S_AXI_RREADY),
		.wr(wr), .rd(rd), .rd_data(rd_data)
	);

	// switches, coefficients and id block
	fir_reg_bank fir_reg_bank_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.wr(wr), .rd(rd), .rd_data(rd_data),
		.coefs(coefs), .fir_en(fir_en), .leds(leds)
	);

	// pipelined convolution
	fir_tap_chain fir_tap_chain_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.fir_in(fir_in), .coefs(coefs), .sum(sum)
	);

	// scale, clamp and bypass
	fir_output_stage fir_output_stage_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.sum(sum), .fir_in(fir_in), .fir_en(fir_en), .fir_out(fir_out)
	);

endmodule

`default_nettype wire

/* dv/fir_axi_props.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_axi_props (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire S_AXI_AWVALID,
	input wire S_AXI_AWREADY,
	input wire S_AXI_WVALID,
	input wire S_AXI_WREADY,
	input wire S_AXI_BVALID,
	input wire S_AXI_BREADY,
	input wire S_AXI_ARREADY,
	input wire S_AXI_RVALID,
	input wire S_AXI_RREADY
);

	// count of failed assertions
	int assert_errors = 0;

	// write response held until the master takes it
	bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
		else begin
			assert_errors++;
			$error("BVALID dropped before BREADY");
		end

	// same rule on the read data channel
	rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID)
		else begin
			assert_errors++;
			$error("RVALID dropped before RREADY");
		end

	// both readies pulse only while address and data are offered together
	aw_with_w: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_AWREADY |-> S_AXI_WREADY && S_AXI_AWVALID && S_AXI_WVALID)
		else begin
			assert_errors++;
			$error("AWREADY without WREADY or outside a write handshake");
		end

	// synchronous reset clears every handshake output
	reset_quiet: assert property (@(posedge S_AXI_ACLK)
		!S_AXI_ARESETN |=> !(S_AXI_AWREADY || S_AXI_WREADY || S_AXI_BVALID ||
		S_AXI_ARREADY || S_AXI_RVALID))
		else begin
			assert_errors++;
			$error("handshake output high after reset");
		end

endmodule

`default_nettype wire

/* dv/fir_axi_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_axi_tb;

	import fir_pkg::*;
	import axi_regs_pkg::*;

	// handshake waits give up after this many cycles
	localparam int wait_limit = 32;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [axi_addr_width-1:0] awaddr;
	logic awvalid;
	logic awready;
	axi_data_t wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [axi_addr_width-1:0] araddr;
	logic arvalid;
	logic arready;
	axi_data_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	sample_t fir_in;
	sample_t fir_out;
	logic [sw_leds_width-1:0] leds;

	// scoreboard
	int errors;
	int checks;
	int tests;
	int test_errors;
	logic [31:0] lcg_state;
	// stimulus stream and the coefficients the model thinks are loaded
	sample_t stim [64];
	longint model_coef [fir_taps];

	fir_axi_top fir_axi_top_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(awaddr), .S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
		.S_AXI_WDATA(wdata), .S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready),
		.S_AXI_BRESP(bresp), .S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready),
		.S_AXI_ARADDR(araddr), .S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
		.S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp), .S_AXI_RVALID(rvalid),
		.S_AXI_RREADY(rready), .fir_in(fir_in), .fir_out(fir_out), .leds(leds)
	);

	bind axi_lite_slave fir_axi_props fir_axi_props_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWVALID(S_AXI_AWVALID), .S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_WVALID(S_AXI_WVALID), .S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BVALID(S_AXI_BVALID), .S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARREADY(S_AXI_ARREADY), .S_AXI_RVALID(S_AXI_RVALID),
		.S_AXI_RREADY(S_AXI_RREADY)
	);

	// 100 ns clock
	always #50 S_AXI_ACLK = ~S_AXI_ACLK;

	function automatic sample_t random_sample();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		// top bits of the state are the most random
		return sample_t'(lcg_state[31:18]);
	endfunction

	function automatic logic [axi_addr_width-1:0] byte_addr(input int word);
		return (axi_addr_width)'(word * 4);
	endfunction

	// bit 31 is the sign, bits 16..0 the low part of an 18 bit value
	function automatic longint coef_value(input axi_data_t w);
		return w[31] ? longint'(w[16:0]) - 131072 : longint'(w[16:0]);
	endfunction

	function automatic axi_data_t coef_readback(input axi_data_t w);
		return {{15{w[31]}}, w[16:0]};
	endfunction

	// reference filter output for the sample driven at index m
	function automatic sample_t model_fir(input int m);
		longint acc;
		longint y;
		acc = 0;
		for (int k = 0; k < fir_taps; k++) begin
			if (m - k >= 0) begin
				acc += model_coef[k] * longint'(stim[m - k]);
			end
		end
		// floor by 2^17, then clamp to 14 bits signed
		y = acc >>> 17;
		if (y > 8191) begin
			y = 8191;
		end else if (y < -8192) begin
			y = -8192;
		end
		return sample_t'(y);
	endfunction

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout at %0t: %s never came from the DUT", $time, what);
	endtask

	task automatic check_word(input axi_data_t got, input axi_data_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s output %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_leds(input logic [sw_leds_width-1:0] got,
		input logic [sw_leds_width-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s show %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input string what);
		checks++;
		if (got !== 2'b00) begin
			errors++;
			$display("Mismatch at %0t: %s is %b, expected OKAY", $time, what, got);
		end
	endtask

	task automatic axi_write(input int word, input axi_data_t data);
		int n;
		@(posedge S_AXI_ACLK);
		awaddr <= byte_addr(word);
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			n++;
		end while (!(awready && wready) && n < wait_limit);
		if (!(awready && wready)) report_timeout("AWREADY and WREADY");
		// handshake completes on this edge
		@(posedge S_AXI_ACLK);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			n++;
		end while (!bvalid && n < wait_limit);
		if (bvalid) begin
			check_resp(bresp, "write response");
		end else begin
			report_timeout("BVALID");
		end
		// response left waiting for one edge before it is taken
		@(posedge S_AXI_ACLK);
		bready <= 1'b1;
		@(posedge S_AXI_ACLK);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input int word, output axi_data_t data);
		int n;
		data = '0;
		@(posedge S_AXI_ACLK);
		araddr <= byte_addr(word);
		arvalid <= 1'b1;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			n++;
		end while (!arready && n < wait_limit);
		if (!arready) report_timeout("ARREADY");
		@(posedge S_AXI_ACLK);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			n++;
		end while (!rvalid && n < wait_limit);
		if (rvalid) begin
			data = rdata;
			check_resp(rresp, "read response");
		end else begin
			report_timeout("RVALID");
		end
		// read data left waiting for one edge before it is taken
		@(posedge S_AXI_ACLK);
		rready <= 1'b1;
		@(posedge S_AXI_ACLK);
		rready <= 1'b0;
	endtask

	task automatic write_coef(input int k, input axi_data_t w);
		axi_write(32 + k, w);
		model_coef[k] = coef_value(w);
	endtask

	// zeros first so pipeline and model share the same history
	task automatic run_stream(input int n, input bit filtered, input string what);
		repeat (12) begin
			@(posedge S_AXI_ACLK);
			fir_in <= '0;
		end
		for (int j = 0; j < n + 4; j++) begin
			@(posedge S_AXI_ACLK);
			fir_in <= (j < n) ? stim[j] : '0;
			@(negedge S_AXI_ACLK);
			// filtered result trails the drive edge by four edges, bypass by one
			if (filtered && j >= 4) begin
				check_sample(fir_out, model_fir(j - 4), what);
			end else if (!filtered && j >= 1 && j <= n) begin
				check_sample(fir_out, stim[j - 1], what);
			end
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s done, %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic test_id_block();
		axi_data_t data;
		axi_read(0, data);
		check_word(data, " RIF", "program name");
		axi_read(1, data);
		check_word(data, "01.3", "program version");
		axi_read(2, data);
		check_word(data, "VED ", "program status");
		axi_read(4, data);
		check_word(data, 32'd8, "tap count");
		axi_read(8, data);
		check_word(data, 32'd17, "coefficient magnitude");
		axi_read(16, data);
		check_word(data, 32'd32, "coefficient base");
		end_test("identification block");
	endtask

	task automatic test_switches();
		axi_data_t data;
		axi_write(20, 32'hdead_be5a);
		axi_read(20, data);
		check_word(data, 32'hdead_be5a, "switches");
		check_leds(leds, 8'h5a, "leds");
		axi_write(20, 32'h0000_00a5);
		axi_read(20, data);
		check_word(data, 32'h0000_00a5, "switches");
		check_leds(leds, 8'ha5, "leds");
		end_test("switch register");
	endtask

	task automatic test_coefs();
		axi_data_t words [fir_taps] = '{32'h0000_2000, 32'h7ffe_0123, 32'h8001_0000,
			32'hffff_ffff, 32'h8000_0000, 32'h0001_ffff, 32'h4000_8000, 32'h8002_1234};
		axi_data_t data;
		for (int k = 0; k < fir_taps; k++) begin
			write_coef(k, words[k]);
		end
		for (int k = 0; k < fir_taps; k++) begin
			axi_read(32 + k, data);
			check_word(data, coef_readback(words[k]), "coefficient");
		end
		// unmapped word next to the switches and the word past the last tap
		axi_write(21, 32'hffff_ffff);
		axi_read(21, data);
		check_word(data, 32'h0, "unmapped word 21");
		axi_write(40, 32'h1234_5678);
		axi_read(40, data);
		check_word(data, 32'h0, "unmapped word 40");
		end_test("coefficient registers");
	endtask

	task automatic test_bypass();
		axi_write(20, 32'h0000_00a5);
		for (int i = 0; i < 40; i++) begin
			stim[i] = random_sample();
		end
		run_stream(40, 1'b0, "bypass");
		end_test("bypass path");
	endtask

	task automatic test_filter();
		axi_data_t words [fir_taps] = '{32'h0000_4000, 32'h0000_c000, 32'h8001_8000,
			32'h0000_2000, 32'h0001_0000, 32'h8001_f000, 32'h0000_0800, 32'h8001_c000};
		axi_write(20, 32'h0000_0002);
		check_leds(leds, 8'h02, "leds");
		for (int k = 0; k < fir_taps; k++) begin
			write_coef(k, words[k]);
		end
		// impulse, a quiet gap for its response, then random data
		stim[0] = sample_t'(4096);
		for (int i = 1; i < 56; i++) begin
			stim[i] = (i < 10) ? sample_t'(0) : random_sample();
		end
		run_stream(56, 1'b1, "filter");
		end_test("filtered path");
	endtask

	task automatic test_saturation();
		for (int k = 0; k < fir_taps; k++) begin
			write_coef(k, 32'h0001_ffff);
		end
		// full scale blocks of both signs long enough to fill all taps
		for (int i = 0; i < 48; i++) begin
			stim[i] = (i % 24 < 12) ? sample_t'(8191) : sample_t'(-8192);
		end
		run_stream(48, 1'b1, "saturation");
		end_test("saturation");
	endtask

	initial begin
		S_AXI_ACLK = 1'b0;
		S_AXI_ARESETN = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		fir_in = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		lcg_state = 32'h6cb9_a81b;
		for (int k = 0; k < fir_taps; k++) begin
			model_coef[k] = 0;
		end
		repeat (8) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		test_id_block();
		test_switches();
		test_coefs();
		test_bypass();
		test_filter();
		test_saturation();
		errors += fir_axi_top_i.axi_lite_slave_i.fir_axi_props_i.assert_errors;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
src/fir_pkg.sv
src/axi_regs_pkg.sv
src/axi_lite_slave.sv
src/fir_reg_bank.sv
src/fir_tap_chain.sv
src/fir_output_stage.sv
src/fir_axi_top.sv
dv/fir_axi_props.sv
dv/fir_axi_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --assert -Wno-fatal --top-module fir_axi_tb -f project.f \
	-Mdir obj_dir -o fir_axi_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/fir_axi_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
